//--- hdl/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

////////////////////
// Machine CSR numbers
////////////////////

`define CSR_MSTATUS  12'h300
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341

// Performance counters
`define CSR_MCYCLE   12'hB00
`define CSR_MLOADS   12'hB03
`define CSR_MSTORES  12'hB04

// Only stored bit of mstatus
`define MSTATUS_MIE_BIT 3

////////////////////
// Debug address map
////////////////////

// Set means the access goes to a CSR
`define DBG_CSR_WINDOW_BIT 14
// CSR number field inside the debug address
`define DBG_CSR_LSB 2
`define DBG_CSR_MSB 13

`endif

//--- hdl/csr_pkg.sv
package csr_pkg;

  // Widths with a meaning
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  typedef logic [14:0] dbg_addr_t;

  // CSR access operation
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // Debug port FSM
  typedef enum logic {
    DBG_IDLE    = 1'b0,
    DBG_RESPOND = 1'b1
  } dbg_state_e;

  // Common write rule, old value modified by the operation
  function automatic csr_data_t csr_apply_op(input csr_op_e op, input csr_data_t old_val,
                                             input csr_data_t operand);
    case (op)
      CSR_OP_WRITE: return operand;
      CSR_OP_SET:   return old_val | operand;
      CSR_OP_CLEAR: return old_val & ~operand;
      default:      return old_val;
    endcase
  endfunction

endpackage

//--- hdl/csr_bus_if.sv
`timescale 1ns/1ps

interface csr_bus_if;
  import csr_pkg::*;

  // Driven by the arbiter
  logic      valid;
  csr_op_e   op;
  csr_addr_t addr;
  csr_data_t wdata;

  // Returns, zero data when not hit
  logic      reg_hit;
  csr_data_t reg_rdata;
  logic      perf_hit;
  csr_data_t perf_rdata;

  modport master (
    output valid, op, addr, wdata,
    input  reg_hit, reg_rdata, perf_hit, perf_rdata
  );

  modport regfile (input valid, op, addr, wdata, output reg_hit, reg_rdata);

  modport perf (input valid, op, addr, wdata, output perf_hit, perf_rdata);

endinterface

//--- hdl/dbg_csr_if.sv
`timescale 1ns/1ps

interface dbg_csr_if;
  import csr_pkg::*;

  // Request side, one cycle per granted window access
  logic      req;
  csr_op_e   op;
  csr_addr_t addr;
  csr_data_t wdata;

  // Return from the arbiter, same cycle
  csr_data_t rdata;
  logic      hit;

  modport requester (output req, op, addr, wdata, input rdata, hit);

  modport arbiter (input req, op, addr, wdata, output rdata, hit);

endinterface

//--- hdl/debug_port.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module debug_port (
  input  logic               clk_i,
  input  logic               rst_ni,

  // External debug bus
  input  logic               debug_req_i,
  input  logic               debug_we_i,
  input  csr_pkg::dbg_addr_t debug_addr_i,
  input  csr_pkg::csr_data_t debug_wdata_i,
  output logic               debug_gnt_o,
  output logic               debug_rvalid_o,
  output csr_pkg::csr_data_t debug_rdata_o,

  // Response pending, keeps the core clock running
  output logic               dbg_active_o,

  dbg_csr_if.requester       dbg
);
  import csr_pkg::*;

  dbg_state_e state_q, state_d;
  logic       csr_window;
  csr_data_t  rdata_q;

  ////////////////////
  // Grant and decode
  ////////////////////

  // No new grant while a response is pending
  assign debug_gnt_o = debug_req_i && (state_q == DBG_IDLE);
  assign csr_window  = debug_addr_i[`DBG_CSR_WINDOW_BIT];

  // Forward only window accesses
  assign dbg.req   = debug_gnt_o && csr_window;
  assign dbg.op    = debug_we_i ? CSR_OP_WRITE : CSR_OP_NONE;
  assign dbg.addr  = debug_addr_i[`DBG_CSR_MSB:`DBG_CSR_LSB];
  assign dbg.wdata = debug_wdata_i;

  // Two states, respond lasts exactly one cycle
  always_comb begin
    state_d = state_q;
    case (state_q)
      DBG_IDLE:    if (debug_gnt_o) state_d = DBG_RESPOND;
      DBG_RESPOND: state_d = DBG_IDLE;
      default:     state_d = DBG_IDLE;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DBG_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Outside window or no target hit reads zero
  always_ff @(posedge clk_i) begin
    if (debug_gnt_o) begin
      rdata_q <= dbg.hit ? dbg.rdata : '0;
    end
  end

  assign debug_rvalid_o = (state_q == DBG_RESPOND);
  assign debug_rdata_o  = rdata_q;
  assign dbg_active_o   = debug_rvalid_o;

endmodule

//--- hdl/csr_arbiter.sv
`timescale 1ns/1ps

module csr_arbiter (
  // Core execute-stage port
  input  logic               csr_access_i,
  input  csr_pkg::csr_op_e   csr_op_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_data_t csr_wdata_i,
  output csr_pkg::csr_data_t csr_rdata_o,
  output logic               csr_stall_o,

  dbg_csr_if.arbiter         dbg,
  csr_bus_if.master          bus
);
  import csr_pkg::*;

  csr_data_t rdata_merged;
  logic      hit_merged;

  ////////////////////
  // Request select
  ////////////////////

  // Debug always wins, core repeats later
  assign csr_stall_o = dbg.req && csr_access_i;

  assign bus.valid = dbg.req || csr_access_i;
  assign bus.op    = dbg.req ? dbg.op    : csr_op_i;
  assign bus.addr  = dbg.req ? dbg.addr  : csr_addr_i;
  assign bus.wdata = dbg.req ? dbg.wdata : csr_wdata_i;

  ////////////////////
  // Return path
  ////////////////////

  // Targets give zero when not hit, so OR is enough
  assign rdata_merged = bus.reg_rdata | bus.perf_rdata;
  assign hit_merged   = bus.reg_hit || bus.perf_hit;

  // Losing side sees zero
  assign dbg.rdata   = dbg.req ? rdata_merged : '0;
  assign dbg.hit     = dbg.req && hit_merged;
  assign csr_rdata_o = dbg.req ? '0 : rdata_merged;

endmodule

//--- hdl/csr_regfile.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_regfile (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Interrupt enable and return address
  output logic               m_irq_enable_o,
  output csr_pkg::csr_data_t mepc_o,

  csr_bus_if.regfile         bus
);
  import csr_pkg::*;

  logic      mie_q;
  csr_data_t mscratch_q;
  csr_data_t mepc_q;

  // Address decode
  logic      sel_mstatus;
  logic      sel_mscratch;
  logic      sel_mepc;

  csr_data_t mstatus_val;
  csr_data_t mstatus_nxt;
  csr_data_t mscratch_nxt;
  csr_data_t mepc_nxt;

  assign sel_mstatus  = (bus.addr == `CSR_MSTATUS);
  assign sel_mscratch = (bus.addr == `CSR_MSCRATCH);
  assign sel_mepc     = (bus.addr == `CSR_MEPC);

  // Hit flag regardless of valid
  assign bus.reg_hit = sel_mstatus || sel_mscratch || sel_mepc;

  ////////////////////
  // Read and next values
  ////////////////////

  always_comb begin
    // mstatus holds MIE only
    mstatus_val                   = '0;
    mstatus_val[`MSTATUS_MIE_BIT] = mie_q;

    mstatus_nxt  = csr_apply_op(bus.op, mstatus_val, bus.wdata);
    mscratch_nxt = csr_apply_op(bus.op, mscratch_q, bus.wdata);
    // Word aligned return address
    mepc_nxt     = csr_apply_op(bus.op, mepc_q, bus.wdata) & ~32'h3;

    bus.reg_rdata = '0;
    if (sel_mstatus)  bus.reg_rdata = mstatus_val;
    if (sel_mscratch) bus.reg_rdata = mscratch_q;
    if (sel_mepc)     bus.reg_rdata = mepc_q;
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q      <= 1'b0;
      mscratch_q <= '0;
      mepc_q     <= '0;
    end else if (bus.valid) begin
      if (sel_mstatus)  mie_q      <= mstatus_nxt[`MSTATUS_MIE_BIT];
      if (sel_mscratch) mscratch_q <= mscratch_nxt;
      if (sel_mepc)     mepc_q     <= mepc_nxt;
    end
  end

  assign m_irq_enable_o = mie_q;
  assign mepc_o         = mepc_q;

endmodule

//--- hdl/perf_counters.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module perf_counters (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Core clock enable, counts active cycles
  input  logic     count_en_i,

  // Data bus events
  input  logic     data_req_i,
  input  logic     data_gnt_i,
  input  logic     data_we_i,

  csr_bus_if.perf  bus
);
  import csr_pkg::*;

  // Index 0 mcycle, 1 mloads, 2 mstores
  csr_data_t  cnt_q [3];
  logic [2:0] sel;
  logic [2:0] inc;
  logic       bus_wr;

  assign sel[0] = (bus.addr == `CSR_MCYCLE);
  assign sel[1] = (bus.addr == `CSR_MLOADS);
  assign sel[2] = (bus.addr == `CSR_MSTORES);

  // Granted requests only
  assign inc[0] = count_en_i;
  assign inc[1] = data_req_i && data_gnt_i && !data_we_i;
  assign inc[2] = data_req_i && data_gnt_i && data_we_i;

  // A read with op none must not block counting
  assign bus_wr = bus.valid && (bus.op != CSR_OP_NONE);

  assign bus.perf_hit = |sel;

  always_comb begin
    bus.perf_rdata = '0;
    for (int i = 0; i < 3; i++) begin
      if (sel[i]) bus.perf_rdata = cnt_q[i];
    end
  end

  ////////////////////
  // Counters
  ////////////////////

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 3; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        // Bus write beats the increment
        if (bus_wr && sel[i]) begin
          cnt_q[i] <= csr_apply_op(bus.op, cnt_q[i], bus.wdata);
        end else if (inc[i]) begin
          cnt_q[i] <= cnt_q[i] + 32'd1;
        end
      end
    end
  end

endmodule

//--- hdl/sleep_ctrl.sv
`timescale 1ns/1ps

module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic busy_i,
  input  logic debug_req_i,
  input  logic dbg_active_i,
  input  logic irq_i,
  input  logic m_irq_enable_i,

  output logic clock_en_o,
  output logic sleeping_o
);

  logic busy_q;

  // Busy level, one cycle late
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= busy_i;
    end
  end

  // Debug traffic or an enabled irq wakes the core
  assign clock_en_o = busy_q || debug_req_i || dbg_active_i || (irq_i && m_irq_enable_i);

  // Idle out of reset
  assign sleeping_o = !busy_q;

endmodule

//--- hdl/csr_subsystem_top.sv
`timescale 1ns/1ps

module csr_subsystem_top (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Core CSR port
  input  logic               csr_access_i,
  input  csr_pkg::csr_op_e   csr_op_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_data_t csr_wdata_i,
  output csr_pkg::csr_data_t csr_rdata_o,
  output logic               csr_stall_o,

  // Debug bus
  input  logic               debug_req_i,
  input  logic               debug_we_i,
  input  csr_pkg::dbg_addr_t debug_addr_i,
  input  csr_pkg::csr_data_t debug_wdata_i,
  output logic               debug_gnt_o,
  output logic               debug_rvalid_o,
  output csr_pkg::csr_data_t debug_rdata_o,

  // Data bus events for the counters
  input  logic               data_req_i,
  input  logic               data_gnt_i,
  input  logic               data_we_i,

  input  logic               irq_i,
  input  logic               busy_i,

  output logic               m_irq_enable_o,
  output csr_pkg::csr_data_t mepc_o,
  output logic               clock_en_o,
  output logic               sleeping_o
);

  logic dbg_active;

  csr_bus_if u_csr_bus ();
  dbg_csr_if u_dbg_csr ();

  ////////////////////
  // CSR requesters
  ////////////////////

  debug_port u_debug_port (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .debug_req_i    (debug_req_i),
    .debug_we_i     (debug_we_i),
    .debug_addr_i   (debug_addr_i),
    .debug_wdata_i  (debug_wdata_i),
    .debug_gnt_o    (debug_gnt_o),
    .debug_rvalid_o (debug_rvalid_o),
    .debug_rdata_o  (debug_rdata_o),
    .dbg_active_o   (dbg_active),
    .dbg            (u_dbg_csr.requester)
  );

  csr_arbiter u_csr_arbiter (
    .csr_access_i (csr_access_i),
    .csr_op_i     (csr_op_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_rdata_o  (csr_rdata_o),
    .csr_stall_o  (csr_stall_o),
    .dbg          (u_dbg_csr.arbiter),
    .bus          (u_csr_bus.master)
  );

  ////////////////////
  // CSR targets
  ////////////////////

  csr_regfile u_csr_regfile (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .m_irq_enable_o (m_irq_enable_o),
    .mepc_o         (mepc_o),
    .bus            (u_csr_bus.regfile)
  );

  // Cycle counter runs on the core clock enable
  perf_counters u_perf_counters (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .count_en_i (clock_en_o),
    .data_req_i (data_req_i),
    .data_gnt_i (data_gnt_i),
    .data_we_i  (data_we_i),
    .bus        (u_csr_bus.perf)
  );

  sleep_ctrl u_sleep_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .busy_i         (busy_i),
    .debug_req_i    (debug_req_i),
    .dbg_active_i   (dbg_active),
    .irq_i          (irq_i),
    .m_irq_enable_i (m_irq_enable_o),
    .clock_en_o     (clock_en_o),
    .sleeping_o     (sleeping_o)
  );

endmodule

//--- verification/tb_csr_subsystem.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module tb_csr_subsystem;
  import csr_pkg::*;

  // Cycles allowed for a debug response
  localparam int RVALID_TIMEOUT = 16;

  typedef enum logic [1:0] {
    KIND_CORE,
    KIND_DBG,
    KIND_DBG_NOWIN,
    KIND_BOTH
  } kind_e;

  typedef struct {
    string     name;
    kind_e     kind;
    csr_op_e   op;
    csr_addr_t addr;
    csr_data_t data;
    csr_data_t exp_rd;
    logic      exp_stall;
  } entry_t;

  logic      clk_i;
  logic      rst_ni;
  logic      csr_access_i;
  csr_op_e   csr_op_i;
  csr_addr_t csr_addr_i;
  csr_data_t csr_wdata_i;
  csr_data_t csr_rdata_o;
  logic      csr_stall_o;
  logic      debug_req_i;
  logic      debug_we_i;
  dbg_addr_t debug_addr_i;
  csr_data_t debug_wdata_i;
  logic      debug_gnt_o;
  logic      debug_rvalid_o;
  csr_data_t debug_rdata_o;
  logic      data_req_i;
  logic      data_gnt_i;
  logic      data_we_i;
  logic      irq_i;
  logic      busy_i;
  logic      m_irq_enable_o;
  csr_data_t mepc_o;
  logic      clock_en_o;
  logic      sleeping_o;

  entry_t      table_q[$];
  logic [31:0] lfsr_q = 32'hf0f4_edc6;

  // Reference CSR state
  logic      model_mie;
  csr_data_t model_mscratch;
  csr_data_t model_mepc;

  csr_subsystem_top u_csr_subsystem_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  function automatic csr_data_t model_op(input csr_op_e op, input csr_data_t old_val,
                                         input csr_data_t arg);
    csr_data_t res;
    res = old_val;
    if (op == CSR_OP_WRITE) res = arg;
    else if (op == CSR_OP_SET) res = old_val | arg;
    else if (op == CSR_OP_CLEAR) res = old_val & ~arg;
    return res;
  endfunction

  function automatic csr_data_t model_read(input csr_addr_t addr);
    csr_data_t val;
    val = '0;
    if (addr == `CSR_MSTATUS) val[`MSTATUS_MIE_BIT] = model_mie;
    else if (addr == `CSR_MSCRATCH) val = model_mscratch;
    else if (addr == `CSR_MEPC) val = model_mepc;
    return val;
  endfunction

  // Counters are tracked apart, not here
  function automatic void model_write(input csr_op_e op, input csr_addr_t addr,
                                      input csr_data_t arg);
    csr_data_t nv;
    nv = model_op(op, model_read(addr), arg);
    if (addr == `CSR_MSTATUS) model_mie = nv[`MSTATUS_MIE_BIT];
    else if (addr == `CSR_MSCRATCH) model_mscratch = nv;
    else if (addr == `CSR_MEPC) model_mepc = nv & 32'hffff_fffc;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, exp_val, act_val);
      $display("tests failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Lands 1 ns after the rising edge
  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic clear_requests();
    csr_access_i  = 1'b0;
    csr_op_i      = CSR_OP_NONE;
    csr_addr_i    = '0;
    csr_wdata_i   = '0;
    debug_req_i   = 1'b0;
    debug_we_i    = 1'b0;
    debug_addr_i  = '0;
    debug_wdata_i = '0;
  endtask

  function automatic void add_entry(input string name, input kind_e kind, input csr_op_e op,
                                    input csr_addr_t addr, input csr_data_t data,
                                    input csr_data_t exp_rd, input logic exp_stall);
    entry_t e;
    e.name      = name;
    e.kind      = kind;
    e.op        = op;
    e.addr      = addr;
    e.data      = data;
    e.exp_rd    = exp_rd;
    e.exp_stall = exp_stall;
    table_q.push_back(e);
  endfunction

  ////////////////////
  // Bus access tasks
  ////////////////////

  // Write lands at the next edge
  task automatic core_access(input csr_op_e op, input csr_addr_t addr, input csr_data_t data,
                             output csr_data_t rdata, output logic stall);
    csr_access_i = 1'b1;
    csr_op_i     = op;
    csr_addr_i   = addr;
    csr_wdata_i  = data;
    #2;
    rdata = csr_rdata_o;
    stall = csr_stall_o;
    tick();
    clear_requests();
    if (!stall) model_write(op, addr, data);
  endtask

  task automatic wait_rvalid(input string name);
    int waited;
    waited = 0;
    #2;
    while (debug_rvalid_o !== 1'b1) begin
      if (waited >= RVALID_TIMEOUT) begin
        $display("Timeout: no debug read-valid for %s", name);
        $display("tests failed");
        $fatal(1, "Debug response never arrived");
      end else begin
        tick();
        #2;
        waited++;
      end
    end
    check_value({name, " rvalid latency"}, 32'd0, 32'(waited));
  endtask

  task automatic debug_access(input string name, input logic we, input logic window,
                              input csr_addr_t addr, input csr_data_t data,
                              output csr_data_t rdata);
    debug_req_i   = 1'b1;
    debug_we_i    = we;
    debug_addr_i  = {window, addr, 2'b00};
    debug_wdata_i = data;
    #2;
    check_value({name, " grant"}, 32'd1, 32'(debug_gnt_o));
    check_value({name, " rvalid in grant cycle"}, 32'd0, 32'(debug_rvalid_o));
    tick();
    clear_requests();
    wait_rvalid(name);
    rdata = debug_rdata_o;
    tick();
    // Single cycle pulse
    check_value({name, " rvalid end"}, 32'd0, 32'(debug_rvalid_o));
    if (window && we) model_write(CSR_OP_WRITE, addr, data);
  endtask

  // Debug write and core op on the same CSR
  // Core repeats its access after the stall
  task automatic combined_access(input entry_t e);
    csr_data_t old_val;
    old_val       = model_read(e.addr);
    csr_access_i  = 1'b1;
    csr_op_i      = e.op;
    csr_addr_i    = e.addr;
    csr_wdata_i   = ~e.data;
    debug_req_i   = 1'b1;
    debug_we_i    = 1'b1;
    debug_addr_i  = {1'b1, e.addr, 2'b00};
    debug_wdata_i = e.data;
    #2;
    check_value({e.name, " stall"}, 32'(e.exp_stall), 32'(csr_stall_o));
    check_value({e.name, " stalled rdata"}, e.exp_rd, csr_rdata_o);
    check_value({e.name, " grant"}, 32'd1, 32'(debug_gnt_o));
    check_value({e.name, " rvalid in grant cycle"}, 32'd0, 32'(debug_rvalid_o));
    tick();
    debug_req_i = 1'b0;
    debug_we_i  = 1'b0;
    model_write(CSR_OP_WRITE, e.addr, e.data);
    #2;
    check_value({e.name, " repeat stall"}, 32'd0, 32'(csr_stall_o));
    check_value({e.name, " repeat rdata"}, model_read(e.addr), csr_rdata_o);
    check_value({e.name, " rvalid"}, 32'd1, 32'(debug_rvalid_o));
    check_value({e.name, " debug rdata"}, old_val, debug_rdata_o);
    tick();
    clear_requests();
    model_write(e.op, e.addr, ~e.data);
  endtask

  task automatic run_data_events(input int cycles, inout logic [31:0] loads,
                                 inout logic [31:0] stores);
    logic [31:0] r;
    for (int i = 0; i < cycles; i++) begin
      take_bits(3, r);
      data_req_i = r[0];
      data_gnt_i = r[1];
      data_we_i  = r[2];
      if (r[0] && r[1] && !r[2]) loads = loads + 32'd1;
      if (r[0] && r[1] && r[2]) stores = stores + 32'd1;
      tick();
    end
    data_req_i = 1'b0;
    data_gnt_i = 1'b0;
    data_we_i  = 1'b0;
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////

  task automatic build_table();
    // mstatus keeps MIE only
    add_entry("wr mstatus", KIND_CORE, CSR_OP_WRITE, `CSR_MSTATUS, 32'hffff_ffff, 32'h0, 1'b0);
    add_entry("rd mstatus", KIND_CORE, CSR_OP_NONE, `CSR_MSTATUS, 32'h0, 32'h8, 1'b0);
    add_entry("clr mstatus", KIND_CORE, CSR_OP_CLEAR, `CSR_MSTATUS, 32'h8, 32'h8, 1'b0);
    add_entry("set mstatus", KIND_CORE, CSR_OP_SET, `CSR_MSTATUS, 32'h8, 32'h0, 1'b0);
    add_entry("wr mscratch", KIND_CORE, CSR_OP_WRITE, `CSR_MSCRATCH, 32'ha5a5_5a5a, 32'h0, 1'b0);
    add_entry("set mscratch", KIND_CORE, CSR_OP_SET, `CSR_MSCRATCH, 32'h0f00_000f,
              32'ha5a5_5a5a, 1'b0);
    add_entry("clr mscratch", KIND_CORE, CSR_OP_CLEAR, `CSR_MSCRATCH, 32'hf000_0000,
              32'hafa5_5a5f, 1'b0);
    add_entry("rd mscratch", KIND_CORE, CSR_OP_NONE, `CSR_MSCRATCH, 32'h0, 32'h0fa5_5a5f, 1'b0);
    // mepc low bits always clear
    add_entry("wr mepc", KIND_CORE, CSR_OP_WRITE, `CSR_MEPC, 32'h1234_5677, 32'h0, 1'b0);
    add_entry("set mepc", KIND_CORE, CSR_OP_SET, `CSR_MEPC, 32'h3, 32'h1234_5674, 1'b0);
    add_entry("clr mepc", KIND_CORE, CSR_OP_CLEAR, `CSR_MEPC, 32'h70, 32'h1234_5674, 1'b0);
    add_entry("rd mepc", KIND_CORE, CSR_OP_NONE, `CSR_MEPC, 32'h0, 32'h1234_5604, 1'b0);
    add_entry("rd unmapped", KIND_CORE, CSR_OP_NONE, 12'h123, 32'h0, 32'h0, 1'b0);
    // Debug window reads return the old value
    add_entry("dbg wr mscratch", KIND_DBG, CSR_OP_WRITE, `CSR_MSCRATCH, 32'hdead_beef,
              32'h0fa5_5a5f, 1'b0);
    add_entry("dbg rd mscratch", KIND_DBG, CSR_OP_NONE, `CSR_MSCRATCH, 32'h0, 32'hdead_beef, 1'b0);
    add_entry("dbg wr mepc", KIND_DBG, CSR_OP_WRITE, `CSR_MEPC, 32'h8000_0003, 32'h1234_5604, 1'b0);
    add_entry("dbg rd mepc", KIND_DBG, CSR_OP_NONE, `CSR_MEPC, 32'h0, 32'h8000_0000, 1'b0);
    add_entry("dbg rd unmapped", KIND_DBG, CSR_OP_NONE, 12'h123, 32'h0, 32'h0, 1'b0);
    // Outside the window
    add_entry("nowin wr", KIND_DBG_NOWIN, CSR_OP_WRITE, `CSR_MSCRATCH, 32'h1111_1111, 32'h0, 1'b0);
    add_entry("nowin rd", KIND_DBG_NOWIN, CSR_OP_NONE, `CSR_MSTATUS, 32'h0, 32'h0, 1'b0);
    add_entry("rd mscratch kept", KIND_CORE, CSR_OP_NONE, `CSR_MSCRATCH, 32'h0, 32'hdead_beef,
              1'b0);
    add_entry("rd mstatus kept", KIND_CORE, CSR_OP_NONE, `CSR_MSTATUS, 32'h0, 32'h8, 1'b0);
    // Debug beats core
    add_entry("both mscratch", KIND_BOTH, CSR_OP_WRITE, `CSR_MSCRATCH, 32'h5555_0000, 32'h0, 1'b1);
    add_entry("rd mscratch after", KIND_CORE, CSR_OP_NONE, `CSR_MSCRATCH, 32'h0, 32'haaaa_ffff,
              1'b0);
    add_entry("both mepc", KIND_BOTH, CSR_OP_WRITE, `CSR_MEPC, 32'h0000_0100, 32'h0, 1'b1);
    add_entry("rd mepc after", KIND_CORE, CSR_OP_NONE, `CSR_MEPC, 32'h0, 32'hffff_fefc, 1'b0);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    entry_t      e;
    csr_data_t   rd;
    csr_data_t   wval;
    csr_data_t   ra;
    csr_data_t   rb;
    logic        stall;
    logic [31:0] load_cnt;
    logic [31:0] store_cnt;
    logic [31:0] en_cnt;
    logic [31:0] r;

    rst_ni = 1'b0;
    clear_requests();
    data_req_i     = 1'b0;
    data_gnt_i     = 1'b0;
    data_we_i      = 1'b0;
    irq_i          = 1'b0;
    busy_i         = 1'b0;
    model_mie      = 1'b0;
    model_mscratch = '0;
    model_mepc     = '0;
    build_table();

    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_value("reset stall", 32'd0, 32'(csr_stall_o));
    check_value("reset gnt", 32'd0, 32'(debug_gnt_o));
    check_value("reset rvalid", 32'd0, 32'(debug_rvalid_o));
    check_value("reset mie", 32'd0, 32'(m_irq_enable_o));
    check_value("reset clock_en", 32'd0, 32'(clock_en_o));
    check_value("reset sleeping", 32'd1, 32'(sleeping_o));
    tick();

    // Register and debug accesses
    foreach (table_q[i]) begin
      e = table_q[i];
      case (e.kind)
        KIND_CORE: begin
          core_access(e.op, e.addr, e.data, rd, stall);
          check_value({e.name, " rdata"}, e.exp_rd, rd);
          check_value({e.name, " stall"}, 32'(e.exp_stall), 32'(stall));
        end
        KIND_DBG, KIND_DBG_NOWIN: begin
          debug_access(e.name, e.op == CSR_OP_WRITE, e.kind == KIND_DBG, e.addr, e.data, rd);
          check_value({e.name, " rdata"}, e.exp_rd, rd);
        end
        default: combined_access(e);
      endcase
      check_value({e.name, " m_irq_enable"}, 32'(model_mie), 32'(m_irq_enable_o));
      check_value({e.name, " mepc_o"}, model_mepc, mepc_o);
    end

    // Load and store counters
    load_cnt  = '0;
    store_cnt = '0;
    run_data_events(40, load_cnt, store_cnt);
    core_access(CSR_OP_NONE, `CSR_MLOADS, 32'h0, rd, stall);
    check_value("mloads", load_cnt, rd);
    core_access(CSR_OP_NONE, `CSR_MSTORES, 32'h0, rd, stall);
    check_value("mstores", store_cnt, rd);
    take_bits(32, wval);
    core_access(CSR_OP_WRITE, `CSR_MLOADS, wval, rd, stall);
    load_cnt = wval;
    run_data_events(30, load_cnt, store_cnt);
    core_access(CSR_OP_NONE, `CSR_MLOADS, 32'h0, rd, stall);
    check_value("mloads after write", load_cnt, rd);
    core_access(CSR_OP_NONE, `CSR_MSTORES, 32'h0, rd, stall);
    check_value("mstores after write", store_cnt, rd);

    // mcycle against enabled cycles seen here
    take_bits(1, r);
    busy_i       = r[0];
    csr_access_i = 1'b1;
    csr_addr_i   = `CSR_MCYCLE;
    #2;
    ra     = csr_rdata_o;
    en_cnt = 32'(clock_en_o);
    tick();
    clear_requests();
    for (int i = 0; i < 20; i++) begin
      take_bits(1, r);
      busy_i = r[0];
      #2;
      if (clock_en_o) en_cnt = en_cnt + 32'd1;
      tick();
    end
    csr_access_i = 1'b1;
    csr_addr_i   = `CSR_MCYCLE;
    #2;
    rb = csr_rdata_o;
    tick();
    clear_requests();
    busy_i = 1'b0;
    check_value("mcycle delta", en_cnt, rb - ra);

    // Sleep follows busy one cycle late
    tick();
    tick();
    check_value("idle sleeping", 32'd1, 32'(sleeping_o));
    check_value("idle clock_en", 32'd0, 32'(clock_en_o));
    busy_i = 1'b1;
    #2;
    check_value("busy same cycle", 32'd1, 32'(sleeping_o));
    check_value("busy same cycle clock_en", 32'd0, 32'(clock_en_o));
    tick();
    check_value("busy sleeping", 32'd0, 32'(sleeping_o));
    check_value("busy clock_en", 32'd1, 32'(clock_en_o));
    busy_i = 1'b0;
    tick();
    check_value("wake sleeping", 32'd1, 32'(sleeping_o));
    check_value("wake clock_en", 32'd0, 32'(clock_en_o));

    // Irq only with MIE set
    core_access(CSR_OP_CLEAR, `CSR_MSTATUS, 32'h8, rd, stall);
    irq_i = 1'b1;
    #2;
    check_value("irq masked clock_en", 32'd0, 32'(clock_en_o));
    tick();
    core_access(CSR_OP_SET, `CSR_MSTATUS, 32'h8, rd, stall);
    #2;
    check_value("irq enabled mie", 32'(model_mie), 32'(m_irq_enable_o));
    check_value("irq enabled clock_en", 32'd1, 32'(clock_en_o));
    tick();
    core_access(CSR_OP_CLEAR, `CSR_MSTATUS, 32'h8, rd, stall);
    #2;
    check_value("irq disabled clock_en", 32'd0, 32'(clock_en_o));
    tick();
    irq_i = 1'b0;

    // Debug request and response keep the clock on
    debug_req_i  = 1'b1;
    debug_addr_i = {1'b1, `CSR_MSTATUS, 2'b00};
    #2;
    check_value("debug req clock_en", 32'd1, 32'(clock_en_o));
    tick();
    clear_requests();
    #2;
    check_value("debug respond clock_en", 32'd1, 32'(clock_en_o));
    tick();
    #2;
    check_value("debug done clock_en", 32'd0, 32'(clock_en_o));
    tick();

    $display("all tests passed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_bus_if.sv
hdl/dbg_csr_if.sv
hdl/debug_port.sv
hdl/csr_arbiter.sv
hdl/csr_regfile.sv
hdl/perf_counters.sv
hdl/sleep_ctrl.sv
hdl/csr_subsystem_top.sv
verification/tb_csr_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the CSR subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_csr_subsystem \
  -f vlog.f -Mdir obj_dir > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vtb_csr_subsystem > sim.log 2>&1
grep -q "tests failed" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "all tests passed" sim.log || { echo "Simulation ended early, see sim.log"; exit 1; }
echo "Simulation PASSED"
